// ==== csr_pkg.sv ====
package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [8:0]  int_lines_t;    // [7:0] hw lines, [8] ipi

    typedef enum logic [2:0]
    {
        NONE,
        CSRRD,
        CSRWR,
        CSRXCHG,
        ERTN,
        TRAP      // exception or interrupt entry
    } csr_op_e;

    // msb first so the struct lines up with the CRMD bit layout
    typedef struct packed
    {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

    localparam crmd_t CRMD_RESET = '{datm: 2'b00, datf: 2'b00, pg: 1'b0, da: 1'b1,
                                     ie: 1'b0, plv: 2'b00};

    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_EUEN   = 14'h2;
    localparam csr_num_t CSR_ECFG   = 14'h4;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_BADV   = 14'h7;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_SAVE1  = 14'h31;
    localparam csr_num_t CSR_SAVE2  = 14'h32;
    localparam csr_num_t CSR_SAVE3  = 14'h33;
    localparam csr_num_t CSR_TID    = 14'h40;
    localparam csr_num_t CSR_TCFG   = 14'h41;
    localparam csr_num_t CSR_TVAL   = 14'h42;
    localparam csr_num_t CSR_TICLR  = 14'h44;

    localparam ecode_t    ECODE_INT = 6'h0;
    localparam ecode_t    ECODE_ADE = 6'h8;
    localparam ecode_t    ECODE_ALE = 6'h9;
    localparam esubcode_t ESUB_ADEM = 9'h1;

    typedef struct packed
    {
        csr_op_e  op;
        csr_num_t num;
        word_t    wdata;
        word_t    mask;   // used by CSRXCHG only
        word_t    pc;
    } csr_cmd_t;

    typedef struct packed
    {
        logic      valid;
        ecode_t    ecode;
        esubcode_t esubcode;
        word_t     badv;
    } excp_t;

    typedef struct packed
    {
        csr_op_e   op;
        csr_num_t  num;
        word_t     wdata;   // merged value, or saved mode bits for TRAP/ERTN
        word_t     pc;
        ecode_t    ecode;
        esubcode_t esubcode;
        word_t     badv;
        logic      badv_valid;
    } commit_t;

endpackage

// ==== csr_timer.sv ====
module csr_timer #(
    parameter int TIMER_W = 32
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               tcfg_wr,
    input  logic [TIMER_W-1:0] tcfg_wdata,
    input  logic               timer_clear,
    output logic [TIMER_W-1:0] tcfg,
    output logic [TIMER_W-1:0] tval,
    output logic               ti
);

    logic               tcfg_new;   // tcfg written last cycle
    logic               en;
    logic               periodic;
    logic               at_zero;
    logic [TIMER_W-1:0] reload;

    assign en       = tcfg[0];
    assign periodic = tcfg[1];
    assign at_zero  = tval == '0;
    assign reload   = {tcfg[TIMER_W-1:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg     <= '0;
            tcfg_new <= 1'b0;
            tval     <= '0;
            ti       <= 1'b0;
        end
        else
        begin
            tcfg_new <= tcfg_wr;
            if (tcfg_wr)
                tcfg <= tcfg_wdata;

            if (timer_clear)      // clear wins
                ti <= 1'b0;
            else if (en && !tcfg_new && at_zero)
                ti <= 1'b1;

            if (en && (tcfg_new || (at_zero && periodic)))
                tval <= reload;
            else if (!en)
                tval <= '0;
            else if (tval != '1)
                tval <= tval - 1'b1;   // one-shot parks at all ones
        end
    end

endmodule

// ==== csr_regfile.sv ====
module csr_regfile #(
    parameter int TIMER_W = 32
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 commit_valid,
    input  csr_pkg::commit_t     commit,
    input  csr_pkg::csr_num_t    rd_num,
    output csr_pkg::word_t       rd_value,
    input  csr_pkg::int_lines_t  int_lines,
    input  logic [TIMER_W-1:0]   tcfg,
    input  logic [TIMER_W-1:0]   tval,
    input  logic                 ti,
    output logic                 tcfg_wr,
    output logic [TIMER_W-1:0]   tcfg_wdata,
    output csr_pkg::crmd_t       crmd,
    output logic [2:0]           prmd,
    output csr_pkg::word_t       eentry,
    output csr_pkg::word_t       era,
    output logic                 int_pending
);
    import csr_pkg::*;

    logic        euen;
    logic [12:0] ecfg_lie;        // bit 10 stays zero
    logic [1:0]  estat_is;        // software interrupts
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    logic [12:0] estat_lines;
    word_t       badv;
    logic [31:6] eentry_base;
    word_t       save [4];
    word_t       tid;
    logic        is_trap;
    logic        is_ertn;
    logic        is_wr;
    word_t       w;

    assign is_trap = commit_valid && commit.op == TRAP;
    assign is_ertn = commit_valid && commit.op == ERTN;
    assign is_wr   = commit_valid && (commit.op == CSRWR || commit.op == CSRXCHG);
    assign w       = commit.wdata;

    assign estat_lines = {int_lines[8], ti, 1'b0, int_lines[7:0], estat_is};
    assign int_pending = |(estat_lines & ecfg_lie);
    assign eentry      = {eentry_base, 6'b0};

    assign tcfg_wr    = is_wr && commit.num == CSR_TCFG;
    assign tcfg_wdata = w[TIMER_W-1:0];

    always_comb
    begin
        rd_value = '0;    // unused numbers and TICLR read as zero
        case (rd_num)
            CSR_CRMD:   rd_value = {23'b0, crmd};
            CSR_PRMD:   rd_value = {29'b0, prmd};
            CSR_EUEN:   rd_value = {31'b0, euen};
            CSR_ECFG:   rd_value = {19'b0, ecfg_lie};
            CSR_ESTAT:  rd_value = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_lines};
            CSR_ERA:    rd_value = era;
            CSR_BADV:   rd_value = badv;
            CSR_EENTRY: rd_value = eentry;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                rd_value = save[rd_num[1:0]];
            CSR_TID:    rd_value = tid;
            CSR_TCFG:   rd_value = word_t'(tcfg);
            CSR_TVAL:   rd_value = word_t'(tval);
            default:    rd_value = '0;
        endcase
    end

    // mode and status
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd           <= CRMD_RESET;
            prmd           <= '0;
            euen           <= 1'b0;
            ecfg_lie       <= '0;
            estat_is       <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            eentry_base    <= '0;
        end
        else if (is_trap)
        begin
            prmd           <= w[2:0];    // {ie, plv} before entry
            crmd.plv       <= 2'b00;
            crmd.ie        <= 1'b0;
            estat_ecode    <= commit.ecode;
            estat_esubcode <= commit.esubcode;
        end
        else if (is_ertn)
        begin
            crmd.plv <= w[1:0];
            crmd.ie  <= w[2];
        end
        else if (is_wr)
        begin
            case (commit.num)
                CSR_CRMD:
                begin
                    crmd.plv  <= w[1:0];
                    crmd.ie   <= w[2];
                    crmd.datf <= w[6:5];
                    crmd.datm <= w[8:7];
                    if (w[3] != w[4])     // da and pg only as a legal pair
                    begin
                        crmd.da <= w[3];
                        crmd.pg <= w[4];
                    end
                end
                CSR_PRMD:   prmd <= w[2:0];
                CSR_EUEN:   euen <= w[0];
                CSR_ECFG:   ecfg_lie <= {w[12:11], 1'b0, w[9:0]};
                CSR_ESTAT:  estat_is <= w[1:0];
                CSR_EENTRY: eentry_base <= w[31:6];
                default:    ;
            endcase
        end
    end

    // data registers
    always_ff @(posedge clk)
    begin
        if (is_trap)
        begin
            era <= commit.pc;
            if (commit.badv_valid)
                badv <= commit.badv;
        end
        else if (is_wr)
        begin
            case (commit.num)
                CSR_ERA:  era <= w;
                CSR_BADV: badv <= w;
                CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                    save[commit.num[1:0]] <= w;
                CSR_TID:  tid <= w;
                default:  ;
            endcase
        end
    end

endmodule

// ==== csr_trap_ctrl.sv ====
module csr_trap_ctrl (
    input  logic              clk,
    input  logic              rstn,
    input  logic              cmd_valid,
    input  csr_pkg::csr_cmd_t cmd,
    input  csr_pkg::excp_t    excp,
    input  logic              stall,
    input  logic              flush,
    input  csr_pkg::word_t    next_pc,
    output csr_pkg::csr_num_t rd_num,
    input  csr_pkg::word_t    rd_value,
    input  csr_pkg::crmd_t    crmd,
    input  logic [2:0]        prmd,
    input  csr_pkg::word_t    eentry,
    input  csr_pkg::word_t    era,
    input  logic              int_pending,
    output logic              commit_valid,
    output csr_pkg::commit_t  commit,
    output logic              timer_clear,
    output csr_pkg::word_t    rdata,
    output logic              redirect_valid,
    output csr_pkg::word_t    redirect_pc,
    output logic              excp_flush,
    output logic              ertn_flush
);
    import csr_pkg::*;

    logic    int_take;
    logic    accept;
    logic    hold_in;        // incoming ERTN keeps the interrupt off
    logic    hold_acc;       // mode may still change in the accept register
    logic    use_badv;
    word_t   wr_mask;
    word_t   merged;
    commit_t sel;
    word_t   sel_rdata;
    logic    sel_redir;
    word_t   sel_pc;
    logic    acc_valid;
    logic    acc_int;
    logic    acc_redir;
    logic    is_wr;

    assign rd_num = cmd.num;

    assign hold_in  = cmd_valid && cmd.op == ERTN;
    assign hold_acc = acc_valid && commit.op != CSRRD && commit.op != NONE;
    assign int_take = int_pending && crmd.ie && !hold_in && !hold_acc;
    assign accept   = int_take || ((cmd_valid || excp.valid) && !stall && !flush);

    assign use_badv = excp.ecode == ECODE_ALE ||
                      (excp.ecode == ECODE_ADE && excp.esubcode == ESUB_ADEM);

    assign wr_mask = (cmd.op == CSRXCHG) ? cmd.mask : '1;
    assign merged  = (rd_value & ~wr_mask) | (cmd.wdata & wr_mask);

    always_comb
    begin
        sel       = '0;
        sel_rdata = '0;
        if (int_take)
        begin
            sel.op    = TRAP;
            sel.pc    = next_pc;      // oldest unretired instruction
            sel.ecode = ECODE_INT;
            sel.wdata = {29'b0, crmd.ie, crmd.plv};
        end
        else if (excp.valid)
        begin
            // the reported exception belongs to the instruction at cmd.pc
            sel.op         = TRAP;
            sel.pc         = cmd.pc;
            sel.ecode      = excp.ecode;
            sel.esubcode   = excp.esubcode;
            sel.badv       = use_badv ? excp.badv : cmd.pc;
            sel.badv_valid = 1'b1;
            sel.wdata      = {29'b0, crmd.ie, crmd.plv};
        end
        else
        begin
            sel.op  = cmd.op;
            sel.num = cmd.num;
            sel.pc  = cmd.pc;
            case (cmd.op)
                CSRRD:            sel_rdata = rd_value;
                CSRWR, CSRXCHG:
                begin
                    sel_rdata = rd_value;   // old value back to rd
                    sel.wdata = merged;
                end
                ERTN:             sel.wdata = {29'b0, prmd};
                default:          sel.wdata = '0;
            endcase
        end
    end

    // redirect target
    always_comb
    begin
        sel_redir = 1'b1;
        sel_pc    = '0;
        case (sel.op)
            TRAP:    sel_pc = eentry;
            ERTN:    sel_pc = era;
            CSRWR, CSRXCHG: sel_pc = sel.pc + 32'd4;   // csr writes may change the mode
            default: sel_redir = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn || !accept)
        begin
            acc_valid <= 1'b0;    // bubble
            acc_int   <= 1'b0;
            acc_redir <= 1'b0;
            rdata     <= '0;
        end
        else
        begin
            acc_valid <= 1'b1;
            acc_int   <= int_take;
            acc_redir <= sel_redir;
            rdata     <= sel_rdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            commit      <= sel;
            redirect_pc <= sel_pc;
        end
    end

    // an external flush kills the item in flight, a taken interrupt survives it
    assign commit_valid   = acc_valid && (!flush || acc_int);
    assign is_wr          = commit.op == CSRWR || commit.op == CSRXCHG;
    assign redirect_valid = commit_valid && acc_redir;
    assign excp_flush     = commit_valid && commit.op == TRAP;
    assign ertn_flush     = commit_valid && commit.op == ERTN;
    assign timer_clear    = commit_valid && is_wr && commit.num == CSR_TICLR &&
                            commit.wdata[0];

endmodule

// ==== csr_unit.sv ====
module csr_unit #(
    parameter int TIMER_W = 32
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                cmd_valid,
    input  csr_pkg::csr_cmd_t   cmd,
    input  csr_pkg::excp_t      excp,
    input  logic                stall,
    input  logic                flush,
    input  csr_pkg::word_t      next_pc,
    input  csr_pkg::int_lines_t int_lines,
    output csr_pkg::word_t      rdata,
    output logic                redirect_valid,
    output csr_pkg::word_t      redirect_pc,
    output logic                excp_flush,
    output logic                ertn_flush,
    output csr_pkg::crmd_t      crmd
);
    import csr_pkg::*;

    csr_num_t           rd_num;
    word_t              rd_value;
    logic [2:0]         prmd;
    word_t              eentry;
    word_t              era;
    logic               int_pending;
    logic               commit_valid;
    commit_t            commit;
    logic               timer_clear;
    logic               tcfg_wr;
    logic [TIMER_W-1:0] tcfg_wdata;
    logic [TIMER_W-1:0] tcfg;
    logic [TIMER_W-1:0] tval;
    logic               ti;

    csr_trap_ctrl trap_ctrl_i (
        .clk            (clk),
        .rstn           (rstn),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .excp           (excp),
        .stall          (stall),
        .flush          (flush),
        .next_pc        (next_pc),
        .rd_num         (rd_num),
        .rd_value       (rd_value),
        .crmd           (crmd),
        .prmd           (prmd),
        .eentry         (eentry),
        .era            (era),
        .int_pending    (int_pending),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .timer_clear    (timer_clear),
        .rdata          (rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .excp_flush     (excp_flush),
        .ertn_flush     (ertn_flush)
    );

    csr_regfile #(
        .TIMER_W (TIMER_W)
    ) regfile_i (
        .clk          (clk),
        .rstn         (rstn),
        .commit_valid (commit_valid),
        .commit       (commit),
        .rd_num       (rd_num),
        .rd_value     (rd_value),
        .int_lines    (int_lines),
        .tcfg         (tcfg),
        .tval         (tval),
        .ti           (ti),
        .tcfg_wr      (tcfg_wr),
        .tcfg_wdata   (tcfg_wdata),
        .crmd         (crmd),
        .prmd         (prmd),
        .eentry       (eentry),
        .era          (era),
        .int_pending  (int_pending)
    );

    csr_timer #(
        .TIMER_W (TIMER_W)
    ) timer_i (
        .clk         (clk),
        .rstn        (rstn),
        .tcfg_wr     (tcfg_wr),
        .tcfg_wdata  (tcfg_wdata),
        .timer_clear (timer_clear),
        .tcfg        (tcfg),
        .tval        (tval),
        .ti          (ti)
    );

endmodule

// ==== tb_csr_checks.svh ====
int    word_errs  = 0;
int    bit_errs   = 0;
int    crmd_errs  = 0;
int    other_errs = 0;
word_t rng_state;

// 32-bit xorshift, steps the shared state
function automatic word_t xorshift32();
    word_t x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp)
    begin
        word_errs++;
        $display("ERR %s expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_crmd(input string name, input crmd_t exp, input crmd_t act);
    if (act !== exp)
    begin
        crmd_errs++;
        $display("ERR %s expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
        bit_errs++;
        $display("ERR %s expected %h actual %h", name, exp, act);
    end
endtask

// polls on falling edges, returns on the cycle the redirect shows up
task automatic wait_redirect(input int max_cycles, output logic seen);
    seen = 1'b0;
    for (int i = 0; i < max_cycles && !seen; i++)
    begin
        @(negedge clk);
        seen = redirect_valid;
    end
    if (!seen)
    begin
        other_errs++;
        $display("timeout: no redirect seen within %0d cycles", max_cycles);
    end
endtask

// ==== tb_csr_unit.sv ====
module tb_csr_unit;
    timeunit 1ns;
    timeprecision 1ps;
    import csr_pkg::*;

    localparam word_t NEXT_PC = 32'h1c00_8000;
    localparam word_t EENTRY  = 32'h1c00_1000;

    logic       clk = 1'b0;
    logic       rstn;
    logic       cmd_valid;
    csr_cmd_t   cmd;
    excp_t      excp;
    logic       stall;
    logic       flush;
    word_t      next_pc;
    int_lines_t int_lines;
    word_t      rdata;
    logic       redirect_valid;
    word_t      redirect_pc;
    logic       excp_flush;
    logic       ertn_flush;
    crmd_t      crmd;

    word_t got_rdata;
    logic  got_redir;
    word_t got_rpc;
    logic  got_xflush;
    logic  got_eflush;
    word_t pc_cnt;       // pc of the next command
    word_t excp_pc;

    `include "tb_csr_checks.svh"

    csr_unit #(
        .TIMER_W (32)
    ) dut_i (
        .clk (clk), .rstn (rstn), .cmd_valid (cmd_valid), .cmd (cmd), .excp (excp),
        .stall (stall), .flush (flush), .next_pc (next_pc), .int_lines (int_lines),
        .rdata (rdata), .redirect_valid (redirect_valid), .redirect_pc (redirect_pc),
        .excp_flush (excp_flush), .ertn_flush (ertn_flush), .crmd (crmd)
    );

    always #2 clk = ~clk;

    task automatic capture_outputs();
        got_rdata  = rdata;
        got_redir  = redirect_valid;
        got_rpc    = redirect_pc;
        got_xflush = excp_flush;
        got_eflush = ertn_flush;
    endtask

    // accepted on the next rising edge, results sampled one cycle later
    task automatic do_cmd(input csr_op_e op, input csr_num_t num, input word_t wdata,
                          input word_t mask);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd       = '{op: op, num: num, wdata: wdata, mask: mask, pc: pc_cnt};
        @(negedge clk);
        capture_outputs();
        cmd_valid = 1'b0;
        cmd       = '0;
    endtask

    task automatic do_excp(input ecode_t ecode, input esubcode_t esub, input word_t badv);
        @(negedge clk);
        excp   = '{valid: 1'b1, ecode: ecode, esubcode: esub, badv: badv};
        cmd.pc = excp_pc;
        @(negedge clk);
        capture_outputs();
        excp = '0;
        cmd  = '0;
    endtask

    task automatic write_csr(input csr_num_t num, input word_t wdata);
        do_cmd(CSRWR, num, wdata, '0);
        check_bit("redirect_valid", 1'b1, got_redir);
        check_word("redirect_pc", pc_cnt + 32'd4, got_rpc);
        pc_cnt += 4;
    endtask

    task automatic read_csr(input csr_num_t num, output word_t value);
        do_cmd(CSRRD, num, '0, '0);
        check_bit("redirect_valid", 1'b0, got_redir);
        value = got_rdata;
        pc_cnt += 4;
    endtask

    task automatic test_save_rw();
        word_t save_exp [4];
        word_t v;
        word_t wd;
        word_t mk;
        word_t merged_exp;
        for (int i = 0; i < 4; i++)
        begin
            save_exp[i] = xorshift32();
            write_csr(CSR_SAVE0 + csr_num_t'(i), save_exp[i]);
        end
        for (int i = 0; i < 4; i++)
        begin
            read_csr(CSR_SAVE0 + csr_num_t'(i), v);
            check_word("save rd", save_exp[i], v);
        end
        wd = xorshift32();
        mk = xorshift32();
        do_cmd(CSRXCHG, CSR_SAVE1, wd, mk);
        check_word("xchg rdata", save_exp[1], got_rdata);
        check_bit("xchg redirect_valid", 1'b1, got_redir);
        check_word("xchg redirect_pc", pc_cnt + 32'd4, got_rpc);
        pc_cnt += 4;
        // per bit, masked bits from wdata
        for (int b = 0; b < 32; b++)
            merged_exp[b] = mk[b] ? wd[b] : save_exp[1][b];
        read_csr(CSR_SAVE1, v);
        check_word("save1 merged", merged_exp, v);
        read_csr(14'h3f, v);
        check_word("unused csr", 32'h0, v);
    endtask

    task automatic test_crmd();
        word_t v;
        read_csr(CSR_CRMD, v);
        check_word("crmd rd", 32'h8, v);
        write_csr(CSR_CRMD, 32'h3);          // da == pg, pair ignored
        read_csr(CSR_CRMD, v);
        check_word("crmd rd", 32'hb, v);
        write_csr(CSR_CRMD, 32'h10);         // pg only
        read_csr(CSR_CRMD, v);
        check_word("crmd rd", 32'h10, v);
        write_csr(CSR_CRMD, 32'h18);         // both set, ignored
        read_csr(CSR_CRMD, v);
        check_word("crmd rd", 32'h10, v);
        write_csr(CSR_CRMD, 32'hf);          // plv 3, ie, back to da
        read_csr(CSR_CRMD, v);
        check_word("crmd rd", 32'hf, v);
        check_crmd("crmd", crmd_t'(9'h00f), crmd);
    endtask

    task automatic test_exception();
        word_t v;
        word_t badv;
        badv    = xorshift32();
        excp_pc = 32'h1c00_0abc;
        write_csr(CSR_EENTRY, EENTRY);
        do_excp(ECODE_ALE, '0, badv);
        check_bit("redirect_valid", 1'b1, got_redir);
        check_word("redirect_pc", EENTRY, got_rpc);
        check_bit("excp_flush", 1'b1, got_xflush);
        read_csr(CSR_ERA, v);
        check_word("era", excp_pc, v);
        read_csr(CSR_ESTAT, v);
        check_word("estat.ecode", word_t'(ECODE_ALE), word_t'(v[21:16]));
        read_csr(CSR_BADV, v);
        check_word("badv", badv, v);
        read_csr(CSR_PRMD, v);
        check_word("prmd", 32'h7, v);
        check_crmd("crmd", crmd_t'(9'h008), crmd);
    endtask

    task automatic test_ertn();
        word_t v;
        do_cmd(ERTN, '0, '0, '0);
        pc_cnt += 4;
        check_bit("redirect_valid", 1'b1, got_redir);
        check_word("redirect_pc", excp_pc, got_rpc);
        check_bit("ertn_flush", 1'b1, got_eflush);
        read_csr(CSR_CRMD, v);
        check_word("crmd rd", 32'hf, v);
        check_crmd("crmd", crmd_t'(9'h00f), crmd);
    endtask

    task automatic test_timer();
        word_t v;
        logic  seen;
        write_csr(CSR_CRMD, 32'h8);
        write_csr(CSR_ECFG, 32'h800);        // lie bit 11, timer
        write_csr(CSR_TCFG, 32'h41);         // one-shot, initial 0x40
        write_csr(CSR_CRMD, 32'hc);
        wait_redirect(300, seen);
        capture_outputs();
        check_word("redirect_pc", EENTRY, got_rpc);
        check_bit("excp_flush", 1'b1, got_xflush);
        read_csr(CSR_ESTAT, v);
        check_word("estat.ecode", word_t'(ECODE_INT), word_t'(v[21:16]));
        check_bit("estat.ti", 1'b1, v[11]);
        read_csr(CSR_ERA, v);
        check_word("era", NEXT_PC, v);
        write_csr(CSR_TICLR, 32'h1);
        read_csr(CSR_ESTAT, v);
        check_bit("estat.ti", 1'b0, v[11]);
    endtask

    task automatic test_stall_flush();
        word_t v;
        word_t s1;
        s1 = xorshift32();
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd       = '{op: CSRWR, num: CSR_SAVE2, wdata: s1, mask: '0, pc: pc_cnt};
        stall     = 1'b1;
        repeat (4)
        begin
            @(negedge clk);
            check_bit("redirect_valid", 1'b0, redirect_valid);
        end
        stall = 1'b0;
        @(negedge clk);
        capture_outputs();
        cmd_valid = 1'b0;
        cmd       = '0;
        check_bit("redirect_valid", 1'b1, got_redir);
        pc_cnt += 4;
        read_csr(CSR_SAVE2, v);
        check_word("save2", s1, v);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd       = '{op: CSRWR, num: CSR_SAVE2, wdata: ~s1, mask: '0, pc: pc_cnt};
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd       = '0;
        flush     = 1'b1;                    // kills the write in flight
        @(negedge clk);
        flush = 1'b0;
        read_csr(CSR_SAVE2, v);
        check_word("save2", s1, v);
    endtask

    initial
    begin
        rstn      = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        excp      = '0;
        stall     = 1'b0;
        flush     = 1'b0;
        next_pc   = NEXT_PC;
        int_lines = '0;
        pc_cnt    = 32'h1c00_0000;
        excp_pc   = '0;
        rng_state = 32'h601c_afc6;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        check_bit("redirect_valid", 1'b0, redirect_valid);
        check_bit("excp_flush", 1'b0, excp_flush);
        check_bit("ertn_flush", 1'b0, ertn_flush);
        check_bit("timer_clear", 1'b0, dut_i.timer_clear);
        check_word("rdata", 32'h0, rdata);
        check_crmd("crmd", crmd_t'(9'h008), crmd);
        test_save_rw();
        test_crmd();
        test_exception();
        test_ertn();
        test_timer();
        test_stall_flush();
        $display("word errors %0d, bit errors %0d, crmd errors %0d, other errors %0d",
                 word_errs, bit_errs, crmd_errs, other_errs);
        if (word_errs + bit_errs + crmd_errs + other_errs == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
csr_pkg.sv
csr_timer.sv
csr_regfile.sv
csr_trap_ctrl.sv
csr_unit.sv
tb_csr_unit.sv
